// ==== pcs_rx_pkg.sv ====
`default_nettype none

package pcs_rx_pkg;

    ////////////////////////////////////////////////////////////
    // Lane and block geometry
    ////////////////////////////////////////////////////////////

    localparam int num_lanes      = 4;
    localparam int block_width    = 64;
    localparam int block_bytes    = block_width / 8;
    localparam int header_width   = 2;
    localparam int errd_cnt_width = 8;

    // Wide enough to count every lane of one cycle in error
    localparam int lane_cnt_width = $clog2(num_lanes + 1);

    ////////////////////////////////////////////////////////////
    // Sync headers and block types
    ////////////////////////////////////////////////////////////

    // Any other header value is malformed
    localparam logic [header_width-1:0] hdr_data = 2'b01;
    localparam logic [header_width-1:0] hdr_ctrl = 2'b10;

    localparam logic [7:0] bt_idle  = 8'h1e;
    localparam logic [7:0] bt_start = 8'h78;

    // Terminate types, bt_termK carries K data bytes ahead of the terminate
    localparam logic [7:0] bt_term0 = 8'h87;
    localparam logic [7:0] bt_term1 = 8'h99;
    localparam logic [7:0] bt_term2 = 8'haa;
    localparam logic [7:0] bt_term3 = 8'hb4;
    localparam logic [7:0] bt_term4 = 8'hcc;
    localparam logic [7:0] bt_term5 = 8'hd2;
    localparam logic [7:0] bt_term6 = 8'he1;
    localparam logic [7:0] bt_term7 = 8'hff;

    ////////////////////////////////////////////////////////////
    // XGMII characters
    ////////////////////////////////////////////////////////////

    localparam logic [7:0] xg_idle  = 8'h07;
    localparam logic [7:0] xg_start = 8'hfb;
    localparam logic [7:0] xg_term  = 8'hfd;
    localparam logic [7:0] xg_error = 8'hfe;

    // Block payload, either eight data bytes or a type byte plus seven bytes.
    // Byte i of the data view sits at bits 8i+7 to 8i
    typedef union packed {
        logic [block_bytes-1:0][7:0] bytes;
        struct packed {
            logic [block_bytes-2:0][7:0] rest;
            logic [7:0]                  type_byte;
        } ctrl;
    } block_payload_u;

endpackage

`default_nettype wire

// ==== lane_block_if.sv ====
`default_nettype none

interface lane_block_if;

    import pcs_rx_pkg::*;

    // One-hot block class, all low for a malformed block
    logic is_data;
    logic is_idle;
    logic is_start;
    logic is_term;

    // XGMII form of the lane, valid only if the class is legal in frame
    logic [block_bytes-1:0] lane_ctrl;
    logic [block_width-1:0] lane_data;

    modport decoder (
        output is_data,
        output is_idle,
        output is_start,
        output is_term,
        output lane_ctrl,
        output lane_data
    );

    modport sequencer (
        input is_data,
        input is_idle,
        input is_start,
        input is_term,
        input lane_ctrl,
        input lane_data
    );

endinterface

`default_nettype wire

// ==== block_decoder.sv ====
`default_nettype none

module block_decoder (
    input  wire [pcs_rx_pkg::header_width-1:0] header_i,
    input  wire [pcs_rx_pkg::block_width-1:0]  data_i,
    lane_block_if.decoder                      blk
);

    import pcs_rx_pkg::*;

    block_payload_u              payload;
    logic [block_bytes-1:0][7:0] shifted;
    logic                        term_type;
    logic [2:0]                  term_len;

    assign payload = data_i;

    // Byte i here is payload byte i+1, top byte unused
    assign shifted = {8'h00, payload.ctrl.rest};

    ////////////////////////////////////////////////////////////
    // Terminate type to data byte count
    ////////////////////////////////////////////////////////////

    always_comb begin
        term_type = 1'b1;
        term_len  = 3'd0;
        case (payload.ctrl.type_byte)
            bt_term0: term_len = 3'd0;
            bt_term1: term_len = 3'd1;
            bt_term2: term_len = 3'd2;
            bt_term3: term_len = 3'd3;
            bt_term4: term_len = 3'd4;
            bt_term5: term_len = 3'd5;
            bt_term6: term_len = 3'd6;
            bt_term7: term_len = 3'd7;
            default:  term_type = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Block class and XGMII form
    ////////////////////////////////////////////////////////////

    always_comb begin
        blk.is_data   = 1'b0;
        blk.is_idle   = 1'b0;
        blk.is_start  = 1'b0;
        blk.is_term   = 1'b0;
        // Malformed blocks get replaced downstream anyway
        blk.lane_ctrl = '1;
        blk.lane_data = {block_bytes{xg_error}};

        if (header_i == hdr_data) begin
            blk.is_data   = 1'b1;
            blk.lane_ctrl = '0;
            blk.lane_data = payload.bytes;
        end else if (header_i == hdr_ctrl) begin
            if (payload.ctrl.type_byte == bt_idle) begin
                blk.is_idle   = 1'b1;
                blk.lane_data = {block_bytes{xg_idle}};
            end else if (payload.ctrl.type_byte == bt_start) begin
                // Start character in byte 0, frame data behind it
                blk.is_start  = 1'b1;
                blk.lane_ctrl = 8'h01;
                blk.lane_data = {payload.ctrl.rest, xg_start};
            end else if (term_type) begin
                blk.is_term = 1'b1;
                for (int i = 0; i < block_bytes; i++) begin
                    if (i < term_len) begin
                        blk.lane_ctrl[i]         = 1'b0;
                        blk.lane_data[8*i +: 8]  = shifted[i];
                    end else if (i == term_len) begin
                        blk.lane_ctrl[i]         = 1'b1;
                        blk.lane_data[8*i +: 8]  = xg_term;
                    end else begin
                        // Idle fill after the terminate
                        blk.lane_ctrl[i]         = 1'b1;
                        blk.lane_data[8*i +: 8]  = xg_idle;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== frame_sequencer.sv ====
`default_nettype none

module frame_sequencer (
    input  wire                    clk_156,
    input  wire                    async_reset_n,
    input  wire                    block_valid_i,
    input  wire                    clear_errblk_i,
    lane_block_if.sequencer        lanes [pcs_rx_pkg::num_lanes],
    output logic                   rx_valid_o,
    output logic [pcs_rx_pkg::num_lanes-1:0][pcs_rx_pkg::block_bytes-1:0] xgmii_rxc_o,
    output logic [pcs_rx_pkg::num_lanes-1:0][pcs_rx_pkg::block_width-1:0] xgmii_rxd_o,
    output logic [pcs_rx_pkg::errd_cnt_width-1:0]                         errd_blks_o
);

    import pcs_rx_pkg::*;

    // Frame state, high while a frame is open
    logic                                    frame_open_q;
    logic [num_lanes:0]                      open_chain;
    logic [num_lanes-1:0]                    lane_ok;
    logic [num_lanes-1:0][block_bytes-1:0]   rxc_nxt;
    logic [num_lanes-1:0][block_width-1:0]   rxd_nxt;
    logic [lane_cnt_width-1:0]               err_cnt;
    logic [errd_cnt_width:0]                 errd_sum;
    logic [errd_cnt_width-1:0]               errd_sat;

    ////////////////////////////////////////////////////////////
    // Frame state chain across the lanes
    ////////////////////////////////////////////////////////////

    // Lane 0 continues from where lane 3 left off last valid cycle
    assign open_chain[0] = frame_open_q;

    for (genvar k = 0; k < num_lanes; k++) begin : g_lane
        assign lane_ok[k] = ((lanes[k].is_data | lanes[k].is_term) & open_chain[k])
                          | ((lanes[k].is_idle | lanes[k].is_start) & ~open_chain[k]);

        // Illegal lanes close the frame
        assign open_chain[k+1] = lane_ok[k] & (lanes[k].is_data | lanes[k].is_start);

        assign rxc_nxt[k] = lane_ok[k] ? lanes[k].lane_ctrl : '1;
        assign rxd_nxt[k] = lane_ok[k] ? lanes[k].lane_data : {block_bytes{xg_error}};
    end

    ////////////////////////////////////////////////////////////
    // Errored block count
    ////////////////////////////////////////////////////////////

    assign err_cnt  = lane_cnt_width'($countones(~lane_ok));
    assign errd_sum = errd_blks_o + err_cnt;

    // Saturate at all ones
    assign errd_sat = errd_sum[errd_cnt_width] ? '1 : errd_sum[errd_cnt_width-1:0];

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            errd_blks_o <= '0;
        end else if (clear_errblk_i) begin
            errd_blks_o <= '0;
        end else if (block_valid_i) begin
            errd_blks_o <= errd_sat;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output and frame state registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            rx_valid_o   <= 1'b0;
            frame_open_q <= 1'b0;
            xgmii_rxc_o  <= '1;
            xgmii_rxd_o  <= {(num_lanes * block_bytes){xg_idle}};
        end else begin
            rx_valid_o <= block_valid_i;
            // Everything holds through a gap in block_valid_i
            if (block_valid_i) begin
                frame_open_q <= open_chain[num_lanes];
                xgmii_rxc_o  <= rxc_nxt;
                xgmii_rxd_o  <= rxd_nxt;
            end
        end
    end

endmodule

`default_nettype wire

// ==== multilane_pcs_rx.sv ====
`default_nettype none

module multilane_pcs_rx (
    input  wire                    clk_156,
    input  wire                    async_reset_n,
    input  wire                    block_valid_i,
    input  wire                    clear_errblk_i,
    input  wire [pcs_rx_pkg::num_lanes-1:0][pcs_rx_pkg::header_width-1:0] rx_header_i,
    input  wire [pcs_rx_pkg::num_lanes-1:0][pcs_rx_pkg::block_width-1:0]  rx_data_i,
    output logic                   rx_valid_o,
    output logic [pcs_rx_pkg::num_lanes-1:0][pcs_rx_pkg::block_bytes-1:0] xgmii_rxc_o,
    output logic [pcs_rx_pkg::num_lanes-1:0][pcs_rx_pkg::block_width-1:0] xgmii_rxd_o,
    output logic [pcs_rx_pkg::errd_cnt_width-1:0]                         errd_blks_o
);

    import pcs_rx_pkg::*;

    ////////////////////////////////////////////////////////////
    // Per-lane block decode
    ////////////////////////////////////////////////////////////

    lane_block_if lane_blk [num_lanes] ();

    // Lane 0 carries the oldest block of the cycle
    for (genvar g = 0; g < num_lanes; g++) begin : g_dec
        block_decoder u_dec (
            .header_i (rx_header_i[g]),
            .data_i   (rx_data_i[g]),
            .blk      (lane_blk[g])
        );
    end

    ////////////////////////////////////////////////////////////
    // Frame state, error substitution and counters
    ////////////////////////////////////////////////////////////

    frame_sequencer u_seq (
        .clk_156        (clk_156),
        .async_reset_n  (async_reset_n),
        .block_valid_i  (block_valid_i),
        .clear_errblk_i (clear_errblk_i),
        .lanes          (lane_blk),
        .rx_valid_o     (rx_valid_o),
        .xgmii_rxc_o    (xgmii_rxc_o),
        .xgmii_rxd_o    (xgmii_rxd_o),
        .errd_blks_o    (errd_blks_o)
    );

endmodule

`default_nettype wire

// ==== multilane_pcs_rx_props.sv ====
`default_nettype none

module multilane_pcs_rx_props (
    input wire                                                        clk_156,
    input wire                                                        async_reset_n,
    input wire                                                        clear_errblk_i,
    input wire                                                        rx_valid_o,
    input wire [pcs_rx_pkg::num_lanes-1:0][pcs_rx_pkg::block_bytes-1:0] xgmii_rxc_o,
    input wire [pcs_rx_pkg::num_lanes-1:0][pcs_rx_pkg::block_width-1:0] xgmii_rxd_o,
    input wire [pcs_rx_pkg::errd_cnt_width-1:0]                       errd_blks_o
);

    timeunit 1ns;
    timeprecision 100ps;

    import pcs_rx_pkg::*;

    // Control bytes may only carry the four XGMII characters in use
    function automatic logic chars_legal(input logic [num_lanes-1:0][block_bytes-1:0] c,
                                         input logic [num_lanes-1:0][block_width-1:0] d);
        logic       ok;
        logic [7:0] b;
        ok = 1'b1;
        for (int l = 0; l < num_lanes; l++) begin
            for (int j = 0; j < block_bytes; j++) begin
                b = d[l][8*j +: 8];
                if (c[l][j] && !(b inside {xg_idle, xg_start, xg_term, xg_error})) ok = 1'b0;
            end
        end
        return ok;
    endfunction

    count_no_drop: assert property (@(posedge clk_156) disable iff (!async_reset_n)
        !$past(clear_errblk_i) |-> errd_blks_o >= $past(errd_blks_o))
        else $error("errd_blks_o dropped without a clear");

    hold_when_idle: assert property (@(posedge clk_156) disable iff (!async_reset_n)
        !rx_valid_o |-> $stable(xgmii_rxc_o) && $stable(xgmii_rxd_o))
        else $error("XGMII outputs changed while rx_valid_o was low");

    legal_bytes: assert property (@(posedge clk_156) disable iff (!async_reset_n)
        chars_legal(xgmii_rxc_o, xgmii_rxd_o))
        else $error("control byte with an unknown XGMII character");

endmodule

bind multilane_pcs_rx multilane_pcs_rx_props u_props (
    .clk_156        (clk_156),
    .async_reset_n  (async_reset_n),
    .clear_errblk_i (clear_errblk_i),
    .rx_valid_o     (rx_valid_o),
    .xgmii_rxc_o    (xgmii_rxc_o),
    .xgmii_rxd_o    (xgmii_rxd_o),
    .errd_blks_o    (errd_blks_o)
);

`default_nettype wire

// ==== tb_multilane_pcs_rx.sv ====
`default_nettype none

module tb_multilane_pcs_rx;

    timeunit 1ns;
    timeprecision 100ps;

    import pcs_rx_pkg::*;

    typedef enum {cls_bad, cls_data, cls_idle, cls_start, cls_term} blk_class_e;

    typedef struct packed {
        logic [num_lanes-1:0][block_bytes-1:0] rxc;
        logic [num_lanes-1:0][block_width-1:0] rxd;
        logic                                  open;
        logic [2:0]                            errs;
    } ref_result_t;

    logic                                   clk_156;
    logic                                   async_reset_n;
    logic                                   block_valid_i;
    logic                                   clear_errblk_i;
    logic [num_lanes-1:0][header_width-1:0] rx_header_i;
    logic [num_lanes-1:0][block_width-1:0]  rx_data_i;
    logic                                   rx_valid_o;
    logic [num_lanes-1:0][block_bytes-1:0]  xgmii_rxc_o;
    logic [num_lanes-1:0][block_width-1:0]  xgmii_rxd_o;
    logic [errd_cnt_width-1:0]              errd_blks_o;

    // Model of the registered DUT state
    logic                                   m_valid;
    logic                                   m_open;
    logic [num_lanes-1:0][block_bytes-1:0]  m_rxc;
    logic [num_lanes-1:0][block_width-1:0]  m_rxd;
    logic [errd_cnt_width-1:0]              m_cnt;

    logic [15:0] lfsr_state = 16'd30949;
    logic [65:0] stream_q [$];

    multilane_pcs_rx dut0 (
        .clk_156        (clk_156),
        .async_reset_n  (async_reset_n),
        .block_valid_i  (block_valid_i),
        .clear_errblk_i (clear_errblk_i),
        .rx_header_i    (rx_header_i),
        .rx_data_i      (rx_data_i),
        .rx_valid_o     (rx_valid_o),
        .xgmii_rxc_o    (xgmii_rxc_o),
        .xgmii_rxd_o    (xgmii_rxd_o),
        .errd_blks_o    (errd_blks_o)
    );

    initial begin
        clk_156 = 1'b0;
        forever #2 clk_156 = ~clk_156;
    end

    ////////////////////////////////////////////////////////////
    // Random bits and block builders
    ////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v[i] = lfsr_state[0];
        end
    endtask

    function automatic logic [7:0] term_code(input int k);
        case (k)
            0:       return bt_term0;
            1:       return bt_term1;
            2:       return bt_term2;
            3:       return bt_term3;
            4:       return bt_term4;
            5:       return bt_term5;
            6:       return bt_term6;
            default: return bt_term7;
        endcase
    endfunction

    task automatic push_ctrl(input logic [7:0] type_byte);
        block_payload_u p;
        logic [63:0]    r;
        take_bits(56, r);
        p.ctrl.rest      = r[55:0];
        p.ctrl.type_byte = type_byte;
        stream_q.push_back({hdr_ctrl, p});
    endtask

    task automatic push_data();
        logic [63:0] r;
        take_bits(64, r);
        stream_q.push_back({hdr_data, r});
    endtask

    task automatic push_term();
        logic [63:0] r;
        take_bits(3, r);
        push_ctrl(term_code(int'(r[2:0])));
    endtask

    task automatic push_raw(input logic [1:0] hdr);
        logic [63:0] r;
        take_bits(64, r);
        stream_q.push_back({hdr, r});
    endtask

    ////////////////////////////////////////////////////////////
    // Expected lane outputs from the frame rules
    ////////////////////////////////////////////////////////////

    function automatic ref_result_t ref_step(
        input logic                                   open_in,
        input logic [num_lanes-1:0][header_width-1:0] hdr,
        input logic [num_lanes-1:0][block_width-1:0]  data
    );
        ref_result_t    r;
        block_payload_u p;
        blk_class_e     cls;
        logic           open;
        logic           legal;
        logic           c;
        logic [7:0]     b;
        int             k;
        r    = '0;
        open = open_in;
        for (int i = 0; i < num_lanes; i++) begin
            p   = data[i];
            k   = -1;
            cls = cls_bad;
            if (hdr[i] == hdr_data) begin
                cls = cls_data;
            end else if (hdr[i] == hdr_ctrl) begin
                for (int t = 0; t < 8; t++) begin
                    if (p.ctrl.type_byte == term_code(t)) k = t;
                end
                if (p.ctrl.type_byte == bt_idle) cls = cls_idle;
                else if (p.ctrl.type_byte == bt_start) cls = cls_start;
                else if (k >= 0) cls = cls_term;
            end
            case (cls)
                cls_data, cls_term:  legal = open;
                cls_idle, cls_start: legal = !open;
                default:             legal = 1'b0;
            endcase
            if (!legal) begin
                r.rxc[i] = '1;
                r.rxd[i] = {block_bytes{xg_error}};
                r.errs   = r.errs + 3'd1;
                open     = 1'b0;
            end else begin
                for (int j = 0; j < block_bytes; j++) begin
                    c = 1'b1;
                    b = xg_idle;
                    if (cls == cls_data) begin
                        c = 1'b0;
                        b = p.bytes[j];
                    end else if (cls == cls_start) begin
                        c = (j == 0);
                        b = (j == 0) ? xg_start : p.bytes[j];
                    end else if (cls == cls_term && j < k) begin
                        c = 1'b0;
                        b = p.bytes[j+1];
                    end else if (cls == cls_term && j == k) begin
                        b = xg_term;
                    end
                    r.rxc[i][j]        = c;
                    r.rxd[i][8*j +: 8] = b;
                end
                open = (cls == cls_data) || (cls == cls_start);
            end
        end
        r.open = open;
        return r;
    endfunction

    task automatic check_value(input logic [255:0] got, input logic [255:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "compare error on %s", what);
        end
    endtask

    // Outputs settle after the rising edge, so compare on the falling one
    initial begin : compare_proc
        ref_result_t res;
        int          sum;
        m_valid = 1'b0;
        m_open  = 1'b0;
        m_rxc   = '1;
        m_rxd   = {(num_lanes * block_bytes){xg_idle}};
        m_cnt   = '0;
        forever begin
            @(negedge clk_156);
            check_value(rx_valid_o, m_valid, "rx_valid_o");
            check_value(xgmii_rxc_o, m_rxc, "xgmii_rxc_o");
            check_value(xgmii_rxd_o, m_rxd, "xgmii_rxd_o");
            check_value(errd_blks_o, m_cnt, "errd_blks_o");
            if (async_reset_n) begin
                m_valid = block_valid_i;
                res     = ref_step(m_open, rx_header_i, rx_data_i);
                sum     = int'(m_cnt) + int'(res.errs);
                if (clear_errblk_i) m_cnt = '0;
                else if (block_valid_i) m_cnt = (sum > 255) ? 8'd255 : sum[7:0];
                if (block_valid_i) begin
                    m_open = res.open;
                    m_rxc  = res.rxc;
                    m_rxd  = res.rxd;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////////////

    task automatic drive_set(input logic valid, input logic clear,
                             input logic [num_lanes-1:0][header_width-1:0] hdr,
                             input logic [num_lanes-1:0][block_width-1:0]  data);
        @(posedge clk_156);
        block_valid_i  <= valid;
        clear_errblk_i <= clear;
        rx_header_i    <= hdr;
        rx_data_i      <= data;
    endtask

    // Four blocks per cycle, idle fill on the last one
    task automatic flush_stream();
        logic [num_lanes-1:0][header_width-1:0] hdr;
        logic [num_lanes-1:0][block_width-1:0]  data;
        logic [65:0]                            blk;
        while (stream_q.size() > 0) begin
            for (int l = 0; l < num_lanes; l++) begin
                if (stream_q.size() > 0) blk = stream_q.pop_front();
                else blk = {hdr_ctrl, 56'h0, bt_idle};
                hdr[l]  = blk[65:64];
                data[l] = blk[63:0];
            end
            drive_set(1'b1, 1'b0, hdr, data);
        end
    endtask

    task automatic drive_gap(input int n);
        logic [63:0] h;
        logic [num_lanes-1:0][block_width-1:0] data;
        for (int c = 0; c < n; c++) begin
            take_bits(8, h);
            for (int l = 0; l < num_lanes; l++) take_bits(64, data[l]);
            drive_set(1'b0, 1'b0, h[7:0], data);
        end
    endtask

    // Stop feeding blocks and wait until the last set has come out
    task automatic drain_and_expect(input int count);
        int waited;
        waited = 0;
        drive_set(1'b0, 1'b0, '0, '0);
        @(negedge clk_156);
        while (rx_valid_o !== 1'b0) begin
            if (waited >= 8) begin
                $display("Timed out waiting for rx_valid_o to fall after the last block set");
                $display("TEST FAILED");
                $fatal(1, "drain timeout");
            end else begin
                @(negedge clk_156);
                waited++;
            end
        end
        check_value(errd_blks_o, count, "errored block count");
    endtask

    initial begin
        async_reset_n  = 1'b0;
        block_valid_i  = 1'b0;
        clear_errblk_i = 1'b0;
        rx_header_i    = '0;
        rx_data_i      = '0;
        for (int c = 0; c < 4; c++) @(posedge clk_156);
        async_reset_n <= 1'b1;
        drive_gap(2);

        // Clean frames of varying length across all lane positions
        for (int f = 0; f < 24; f++) begin
            push_ctrl(bt_start);
            for (int d = 0; d < f % 5; d++) push_data();
            push_term();
            if (f % 3 == 2) push_ctrl(bt_idle);
        end
        flush_stream();
        drain_and_expect(0);

        // Frame held open across a gap in block_valid_i
        push_ctrl(bt_start);
        repeat (3) push_data();
        flush_stream();
        drive_gap(5);
        push_data();
        push_data();
        push_term();
        push_ctrl(bt_idle);
        flush_stream();
        drain_and_expect(0);

        // Data while closed, start and idle while open, terminate while closed
        push_data();
        push_ctrl(bt_idle);
        push_ctrl(bt_start);
        push_data();
        push_ctrl(bt_start);
        push_ctrl(bt_idle);
        push_ctrl(bt_start);
        push_data();
        push_ctrl(bt_idle);
        push_term();
        push_ctrl(bt_idle);
        push_ctrl(bt_idle);
        flush_stream();
        drain_and_expect(4);

        // Bad headers and unknown control types
        push_raw(2'b00);
        push_raw(2'b11);
        push_ctrl(8'h55);
        push_ctrl(8'h33);
        push_ctrl(bt_start);
        push_data();
        push_raw(2'b11);
        push_ctrl(bt_idle);
        flush_stream();
        drain_and_expect(9);

        // Saturation, then clear with and without valid blocks
        repeat (280) push_raw(2'b00);
        flush_stream();
        drain_and_expect(255);
        drive_set(1'b1, 1'b1, '0, '0);
        drain_and_expect(0);
        drive_set(1'b1, 1'b0, '0, '0);
        drive_set(1'b0, 1'b1, '0, '0);
        drain_and_expect(0);

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
pcs_rx_pkg.sv
lane_block_if.sv
block_decoder.sv
frame_sequencer.sv
multilane_pcs_rx.sv
multilane_pcs_rx_props.sv
tb_multilane_pcs_rx.sv

// ==== Bender.yml ====
package:
  name: multilane_pcs_rx

sources:
  - files:
      - pcs_rx_pkg.sv
      - lane_block_if.sv
      - block_decoder.sv
      - frame_sequencer.sv
      - multilane_pcs_rx.sv
  - target: test
    files:
      - multilane_pcs_rx_props.sv
      - tb_multilane_pcs_rx.sv
